// File: logic/isaPkg.sv
// instruction word layout and opcode constants
// register index type and nop encoding
package isaPkg;

   // three-bit register index, eight registers
   typedef logic [2:0] regIdxT;

   // opcode in the top five bits, then rs and rt
   typedef struct packed {
      logic [4:0] opcode;
      regIdxT     rs;
      regIdxT     rt;
      logic [4:0] low;
   } instrT;

   // opcodes the fetch stage cares about
   localparam logic [4:0] opNop     = 5'b00001;
   localparam logic [4:0] opJump    = 5'b00100;
   localparam logic [4:0] opBranch  = 5'b01100;
   localparam logic [4:0] opLoad    = 5'b10001;
   // opcodes that read rt as a source
   localparam logic [4:0] opStore   = 5'b10000;
   localparam logic [4:0] opStoreU  = 5'b10011;
   localparam logic [4:0] opShiftRR = 5'b11010;
   localparam logic [4:0] opAluRR   = 5'b11011;

   // all fields zero apart from the opcode
   localparam logic [15:0] nopWord = {opNop, 11'b0};

   // true when the opcode reads its rt field
   function automatic logic usesRt(input logic [4:0] opcode);
      logic reads;
      case (opcode)
         opStore, opStoreU, opShiftRR, opAluRR: reads = 1'b1;
         // set-on-compare group 111xx
         default: reads = (opcode[4:2] == 3'b111);
      endcase
      return reads;
   endfunction

endpackage

// File: logic/fetchPkg.sv
// pipeline status struct, forwarding and writeback codes
// fetch output bundle
package fetchPkg;

   // where a later stage takes its writeback data from
   typedef enum logic [1:0] {
      wbAlu  = 2'b00,
      wbLoad = 2'b01,
      wbPc   = 2'b10,
      wbImm  = 2'b11
   } wbSelT;

   // forwarding source for one operand
   // fwdNone means read the register file
   typedef enum logic [1:0] {
      fwdNone  = 2'b00,
      fwdFromX = 2'b01,
      fwdFromM = 2'b10,
      fwdFromW = 2'b11
   } fwdSelT;

   // status of one later pipeline stage, 7 bits
   typedef struct packed {
      logic            regWrt;
      isaPkg::regIdxT  wrtReg;
      logic            branchInst;
      wbSelT           wbSel;
   } stageStatT;

   // what fetch hands to decode, 33 bits
   typedef struct packed {
      isaPkg::instrT instruction;
      logic [15:0]   incPC;
      logic          instrValid;
   } fetchOutT;

   // width sanity for the bundles
   localparam int stageStatBits = $bits(stageStatT);
   localparam int fetchOutBits  = $bits(fetchOutT);

endpackage

// File: logic/pcSequencer.sv
// program counter register and +2 incrementer
// redirect selection for resolved branches
`timescale 1ns/1ns
`default_nettype none

module pcSequencer #(
   parameter logic [15:0] resetPc = 16'h0000
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] newPC,
   input  logic        redirect,
   input  logic        hold,
   output logic [15:0] pcAddr,
   output logic [15:0] incPC,
   output logic        err
);

   // next pc before the write enable
   logic [15:0] pcNext;
   // carry out of the incrementer
   logic        carryOut;

   // unsigned add of 2 on a 17-bit result
   assign {carryOut, incPC} = {1'b0, pcAddr} + 17'd2;

   // wrapping past 16'hFFFE is an error
   assign err = carryOut;

   // branch target from writeback wins over sequential fetch
   assign pcNext = redirect ? newPC : incPC;

   // pc register
   // hold covers dump, memory stall and a hazard nop
   // a redirect already cleared the nop part of hold upstream
   always_ff @(posedge clk) begin
      if (reset) begin
         pcAddr <= resetPc;
      end else if (!hold) begin
         pcAddr <= pcNext;
      end
   end

   // odd pc only reachable through an odd redirect target
   aPcEven: assert property (
      @(posedge clk) disable iff (reset)
      $rose(pcAddr[0]) |-> $past(redirect && newPC[0] && !hold)
   ) else $error("pcAddr became odd without an odd redirect");

endmodule

`default_nettype wire

// File: logic/instrMemory.sv
// read-only instruction memory with variable latency
// direct-mapped line record, miss countdown and alignment check
`timescale 1ns/1ns
`default_nettype none

module instrMemory #(
   parameter int memWords    = 256,
   parameter int lineWords   = 4,
   parameter int missLatency = 3
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          createDump,
   input  logic [15:0]   addr,
   output isaPkg::instrT rdata,
   output logic          stall,
   output logic          alignErr
);
   import isaPkg::*;

   // address split
   // byte address bit 0 is the alignment bit
   localparam int wordBits = $clog2(memWords);
   localparam int offBits  = $clog2(lineWords);
   localparam int numLines = memWords / lineWords;
   localparam int idxBits  = $clog2(numLines);
   localparam int tagBits  = 15 - offBits - idxBits;
   // counter holds 1..missLatency
   localparam int cntBits  = $clog2(missLatency + 1);

   // program image
   logic [15:0] mem [memWords];

   // line presence record
   logic [numLines-1:0] lineValid;
   logic [tagBits-1:0]  tagMem [numLines];

   // remaining stall cycles of the current miss
   logic [cntBits-1:0] missCnt;

   logic [wordBits-1:0] wordIdx;
   logic [idxBits-1:0]  lineIdx;
   logic [tagBits-1:0]  lineTag;
   logic                tagMatch;
   logic                fillNow;

   initial begin
      $readmemh("imem.hex", mem);
   end

   // word index wraps at the memory depth
   assign wordIdx = addr[wordBits:1];
   assign lineIdx = addr[offBits+idxBits:offBits+1];
   assign lineTag = addr[15:offBits+idxBits+1];

   assign tagMatch = lineValid[lineIdx] && (tagMem[lineIdx] == lineTag);

   // odd address is flagged and never waits
   assign alignErr = addr[0];
   assign stall    = !alignErr && !tagMatch;

   // read is always combinational
   // valid only when stall is low
   assign rdata = instrT'(mem[wordIdx]);

   // last stalled cycle of a miss
   // countdown pauses during a dump
   assign fillNow = stall && !createDump && (missCnt == cntBits'(1));

   // miss countdown and presence bits
   always_ff @(posedge clk) begin
      if (reset) begin
         lineValid <= '0;
         missCnt   <= cntBits'(missLatency);
      end else if (stall && !createDump) begin
         if (fillNow) begin
            lineValid[lineIdx] <= 1'b1;
            missCnt            <= cntBits'(missLatency);
         end else begin
            missCnt <= missCnt - 1'b1;
         end
      end
   end

   // tag written together with its valid bit
   always_ff @(posedge clk) begin
      if (fillNow) begin
         tagMem[lineIdx] <= lineTag;
      end
   end

   // pc is held during stall so every stalled cycle counts down by one
   aMissCount: assert property (
      @(posedge clk) disable iff (reset)
      (stall && !createDump && missCnt > cntBits'(1))
         |=> (stall && missCnt == $past(missCnt) - 1'b1)
   ) else $error("miss counter skipped or underflowed");

   // fill on the last miss cycle gives a hit on the held address
   aFillHit: assert property (
      @(posedge clk) disable iff (reset)
      fillNow |=> (tagMatch && !stall)
   ) else $error("stall still high after line fill");

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
// hazard detection for the fetch stage
// load-use and branch-shadow nops, operand forwarding selects
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
   input  isaPkg::instrT       fetchWord,
   input  logic                stall,
   input  logic [15:0]         incPC,
   input  fetchPkg::stageStatT statD,
   input  fetchPkg::stageStatT statX,
   input  fetchPkg::stageStatT statM,
   input  fetchPkg::stageStatT statW,
   output logic                pcNop,
   output fetchPkg::fetchOutT  fetchOut,
   output fetchPkg::fwdSelT    fwdA,
   output fetchPkg::fwdSelT    fwdB
);
   import isaPkg::*;
   import fetchPkg::*;

   // source registers of the fetched word
   regIdxT srcA;
   regIdxT srcB;
   // rt only matters for some opcodes
   logic   readsRt;

   // load sitting in decode
   logic   dIsLoad;
   logic   loadHitsRs;
   logic   loadHitsRt;
   logic   loadUse;

   // any branch not yet resolved
   logic   branchInFlight;
   logic   branchShadow;

   // youngest writing stage whose destination matches src
   // x is youngest, then m, then w
   function automatic fwdSelT pickFwd(
      input regIdxT    src,
      input stageStatT sx,
      input stageStatT sm,
      input stageStatT sw
   );
      fwdSelT sel;
      if (sx.regWrt && sx.wrtReg == src) begin
         sel = fwdFromX;
      end else if (sm.regWrt && sm.wrtReg == src) begin
         sel = fwdFromM;
      end else if (sw.regWrt && sw.wrtReg == src) begin
         sel = fwdFromW;
      end else begin
         sel = fwdNone;
      end
      return sel;
   endfunction

   assign srcA    = fetchWord.rs;
   assign srcB    = fetchWord.rt;
   assign readsRt = usesRt(fetchWord.opcode);

   // load result not ready until after memory
   assign dIsLoad = statD.regWrt && (statD.wbSel == wbLoad);

   // rs is always treated as read
   assign loadHitsRs = dIsLoad && (statD.wrtReg == srcA);
   assign loadHitsRt = dIsLoad && readsRt && (statD.wrtReg == srcB);
   assign loadUse    = loadHitsRs || loadHitsRt;

   // branch in d, x or m keeps fetch quiet
   assign branchInFlight = statD.branchInst || statX.branchInst || statM.branchInst;

   // branch in writeback redirects this cycle
   // so the shadow ends there
   assign branchShadow = branchInFlight && !statW.branchInst;

   // either hazard holds the pc and sends a bubble
   assign pcNop = loadUse || branchShadow;

   // output bundle toward decode
   always_comb begin
      fetchOut.incPC      = incPC;
      // word only meaningful once memory stops stalling
      fetchOut.instrValid = !stall;
      if (pcNop) begin
         fetchOut.instruction = instrT'(nopWord);
      end else begin
         fetchOut.instruction = fetchWord;
      end
   end

   // forwarding for both operands
   always_comb begin
      fwdA = pickFwd(srcA, statX, statM, statW);
      fwdB = pickFwd(srcB, statX, statM, statW);
   end

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
// fetch stage top level
// pc sequencer, instruction memory and hazard unit
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
   parameter int          memWords    = 256,
   parameter int          lineWords   = 4,
   parameter int          missLatency = 3,
   parameter logic [15:0] resetPc     = 16'h0000
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                createDump,
   input  logic [15:0]         newPC,
   input  fetchPkg::stageStatT statD,
   input  fetchPkg::stageStatT statX,
   input  fetchPkg::stageStatT statM,
   input  fetchPkg::stageStatT statW,
   output fetchPkg::fetchOutT  fetchOut,
   output fetchPkg::fwdSelT    fwdA,
   output fetchPkg::fwdSelT    fwdB,
   output logic                stall,
   output logic                alignErr,
   output logic                err
);
   import isaPkg::*;

   logic [15:0] pcAddr;
   logic [15:0] incPC;
   instrT       fetchWord;
   logic        pcNop;
   logic        hold;

   // a writeback redirect overrides a hazard nop
   // but never a stall or a dump
   assign hold = createDump | stall | (pcNop & ~statW.branchInst);

   pcSequencer #(.resetPc(resetPc)) i_pcSequencer (
      .clk(clk), .reset(reset), .newPC(newPC), .redirect(statW.branchInst),
      .hold(hold), .pcAddr(pcAddr), .incPC(incPC), .err(err)
   );

   instrMemory #(
      .memWords(memWords), .lineWords(lineWords), .missLatency(missLatency)
   ) i_instrMemory (
      .clk(clk), .reset(reset), .createDump(createDump), .addr(pcAddr),
      .rdata(fetchWord), .stall(stall), .alignErr(alignErr)
   );

   hazardUnit i_hazardUnit (
      .fetchWord(fetchWord), .stall(stall), .incPC(incPC),
      .statD(statD), .statX(statX), .statM(statM), .statW(statW),
      .pcNop(pcNop), .fetchOut(fetchOut), .fwdA(fwdA), .fwdB(fwdB)
   );

endmodule

`default_nettype wire

// File: tests/fetchChecks.svh
// error counters and concurrent checks of the fetch stage
// against the reference pc and line model
`ifndef fetchChecksSvh
`define fetchChecksSvh

int valueErrs = 0;
int holdErrs  = 0;

// latency against the line model
aStall: assert property (@(posedge clk) disable iff (reset) stall === expStall)
   else begin
      valueErrs++;
      $display("[ERROR] %0t stall expected %b actual %b",
         $time, $sampled(expStall), $sampled(stall));
   end

aValid: assert property (@(posedge clk) disable iff (reset)
   fetchOut.instrValid === !expStall)
   else begin
      valueErrs++;
      $display("[ERROR] %0t instrValid expected %b actual %b",
         $time, $sampled(!expStall), $sampled(fetchOut.instrValid));
   end

// incPC tracks pc + 2 of the model
aIncPc: assert property (@(posedge clk) disable iff (reset) fetchOut.incPC === expInc)
   else begin
      valueErrs++;
      $display("[ERROR] %0t incPC expected %h actual %h",
         $time, $sampled(expInc), $sampled(fetchOut.incPC));
   end

// image word or bubble once the memory delivers
aInstr: assert property (@(posedge clk) disable iff (reset)
   !expStall |-> fetchOut.instruction === expInstr)
   else begin
      valueErrs++;
      $display("[ERROR] %0t instruction expected %h actual %h",
         $time, $sampled(expInstr), $sampled(fetchOut.instruction));
   end

aFwdA: assert property (@(posedge clk) disable iff (reset) fwdA === expFwdA)
   else begin
      valueErrs++;
      $display("[ERROR] %0t fwdA expected %0d actual %0d",
         $time, $sampled(expFwdA), $sampled(fwdA));
   end

aFwdB: assert property (@(posedge clk) disable iff (reset) fwdB === expFwdB)
   else begin
      valueErrs++;
      $display("[ERROR] %0t fwdB expected %0d actual %0d",
         $time, $sampled(expFwdB), $sampled(fwdB));
   end

aAlign: assert property (@(posedge clk) disable iff (reset) alignErr === modelPc[0])
   else begin
      valueErrs++;
      $display("[ERROR] %0t alignErr expected %b actual %b",
         $time, $sampled(modelPc[0]), $sampled(alignErr));
   end

aErr: assert property (@(posedge clk) disable iff (reset) err === expErr)
   else begin
      valueErrs++;
      $display("[ERROR] %0t err expected %b actual %b",
         $time, $sampled(expErr), $sampled(err));
   end

// load in decode holds the pc unless writeback redirects
aLoadHold: assert property (@(posedge clk) disable iff (reset)
   (expLoadUse && !statW.branchInst) |=> $stable(fetchOut.incPC))
   else begin
      holdErrs++;
      $display("%0t: pc moved in the cycle after a load-use hazard", $time);
   end

aDumpFreeze: assert property (@(posedge clk) disable iff (reset)
   createDump |=> $stable(fetchOut.incPC))
   else begin
      holdErrs++;
      $display("%0t: pc moved while a dump was requested", $time);
   end

`endif

// File: tests/fetchStageTb.sv
// testbench for the fetch stage top level
// reference pc and line model, phased stimulus, timeout and report
`timescale 1ns/1ns

module fetchStageTb;
   import isaPkg::*;
   import fetchPkg::*;

   localparam int          memWords      = 256;
   localparam int          lineWords     = 4;
   localparam int          missLatency   = 3;
   localparam logic [15:0] resetPc       = 16'h0000;
   localparam int          numLines      = memWords / lineWords;
   // phases take about 400 cycles
   localparam int          timeoutCycles = 2000;

   logic        clk;
   logic        reset;
   logic        createDump;
   logic [15:0] newPC;
   stageStatT   statD, statX, statM, statW;
   fetchOutT    fetchOut;
   fwdSelT      fwdA, fwdB;
   logic        stall, alignErr, err;

   integer      seed;
   int          cycleCount = 0;
   logic [15:0] image [memWords];

   // reference state
   logic [15:0] modelPc;
   logic [numLines-1:0] lineSeen;
   int          lineTagRef [numLines];
   int          missRun;
   int          refIdx, refTag;

   // expected values
   instrT       wordRef, expInstr;
   logic [15:0] expInc;
   logic        expStall, expLoadUse, expShadow, expNop, expErr;
   fwdSelT      expFwdA, expFwdB;

   fetchStage #(
      .memWords(memWords), .lineWords(lineWords),
      .missLatency(missLatency), .resetPc(resetPc)
   ) i_fetchStage (
      .clk(clk), .reset(reset), .createDump(createDump), .newPC(newPC),
      .statD(statD), .statX(statX), .statM(statM), .statW(statW),
      .fetchOut(fetchOut), .fwdA(fwdA), .fwdB(fwdB),
      .stall(stall), .alignErr(alignErr), .err(err)
   );

   always #20 clk = ~clk;

   // X is youngest, a younger match overrides an older one
   function automatic fwdSelT youngestWriter(input regIdxT src, input stageStatT sx,
                                             input stageStatT sm, input stageStatT sw);
      stageStatT stages [3];
      fwdSelT    codes [3];
      fwdSelT    sel;
      stages = '{sx, sm, sw};
      codes  = '{fwdFromX, fwdFromM, fwdFromW};
      sel    = fwdNone;
      for (int i = 2; i >= 0; i--) begin
         if (stages[i].regWrt && stages[i].wrtReg == src) begin
            sel = codes[i];
         end
      end
      return sel;
   endfunction

   always_comb begin
      int lineNum;
      // byte address to line number, then direct-mapped split
      lineNum  = int'(modelPc) / (2 * lineWords);
      refIdx   = lineNum % numLines;
      refTag   = lineNum / numLines;
      expStall = !modelPc[0] && !(lineSeen[refIdx] && lineTagRef[refIdx] == refTag);
      wordRef  = instrT'(image[(int'(modelPc) / 2) % memWords]);
      expLoadUse = statD.regWrt && statD.wbSel == wbLoad &&
         (statD.wrtReg == wordRef.rs ||
          (usesRt(wordRef.opcode) && statD.wrtReg == wordRef.rt));
      expShadow = (statD.branchInst || statX.branchInst || statM.branchInst) &&
         !statW.branchInst;
      expNop   = expLoadUse || expShadow;
      expInstr = expNop ? instrT'(nopWord) : wordRef;
      expInc   = modelPc + 16'd2;
      expErr   = (int'(modelPc) + 2) > 65535;
      expFwdA  = youngestWriter(wordRef.rs, statX, statM, statW);
      expFwdB  = youngestWriter(wordRef.rt, statX, statM, statW);
   end

   // pc write rule and miss countdown of the model
   always_ff @(posedge clk) begin
      if (reset) begin
         modelPc  <= resetPc;
         lineSeen <= '0;
         missRun  <= 0;
      end else begin
         if (expStall && !createDump) begin
            if (missRun == missLatency - 1) begin
               lineSeen[refIdx]   <= 1'b1;
               lineTagRef[refIdx] <= refTag;
               missRun            <= 0;
            end else begin
               missRun <= missRun + 1;
            end
         end
         if (!createDump && !expStall && (statW.branchInst || !expNop)) begin
            modelPc <= statW.branchInst ? newPC : expInc;
         end
      end
   end

   `include "fetchChecks.svh"

   function automatic stageStatT randomStatus();
      logic [31:0] r;
      stageStatT   s;
      r            = $random(seed);
      s.regWrt     = r[0];
      s.wrtReg     = r[3:1];
      s.branchInst = (r[7:4] == 4'd0);
      s.wbSel      = wbSelT'(r[9:8]);
      return s;
   endfunction

   task automatic quietStages();
      statD      = '0;
      statX      = '0;
      statM      = '0;
      statW      = '0;
      createDump = 1'b0;
      newPC      = 16'h0000;
   endtask

   // resolved branch in writeback, issued only when memory is not stalling
   task automatic redirectTo(input logic [15:0] target);
      @(negedge clk);
      while (stall) @(negedge clk);
      statW.branchInst = 1'b1;
      newPC            = target;
      @(negedge clk);
      statW.branchInst = 1'b0;
   endtask

   task automatic loadUseHold();
      @(negedge clk);
      while (stall) @(negedge clk);
      statD.regWrt = 1'b1;
      statD.wrtReg = wordRef.rs;
      statD.wbSel  = wbLoad;
      repeat (3) @(negedge clk);
      statD = '0;
   endtask

   task automatic randomTraffic(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         statD      = randomStatus();
         statX      = randomStatus();
         statM      = randomStatus();
         statW      = randomStatus();
         createDump = (($random(seed) & 15) == 0);
         newPC      = 16'($random(seed)) & 16'h00FE;
      end
      quietStages();
   endtask

   initial begin
      seed  = 32'hacac9023;
      $readmemh("imem.hex", image);
      clk   = 1'b0;
      reset = 1'b1;
      quietStages();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // sequential fetch across several lines
      repeat (60) @(negedge clk);
      // back into a line already present
      redirectTo(16'h0004);
      repeat (6) @(negedge clk);

      // branch shadow from X, then redirect while D still holds a branch
      statX.branchInst = 1'b1;
      repeat (3) @(negedge clk);
      statX.branchInst = 1'b0;
      statD.branchInst = 1'b1;
      redirectTo(16'h0008);
      statD.branchInst = 1'b0;
      repeat (4) @(negedge clk);

      loadUseHold();
      repeat (4) @(negedge clk);

      randomTraffic(200);

      // odd target, then wrap at the top of the address space
      redirectTo(16'h0011);
      repeat (4) @(negedge clk);
      redirectTo(16'h0020);
      repeat (8) @(negedge clk);
      redirectTo(16'hFFFE);
      repeat (8) @(negedge clk);

      // dump across a miss and across hits
      redirectTo(16'h00C0);
      createDump = 1'b1;
      repeat (5) @(negedge clk);
      createDump = 1'b0;
      repeat (8) @(negedge clk);
      createDump = 1'b1;
      repeat (3) @(negedge clk);
      createDump = 1'b0;
      repeat (4) @(negedge clk);

      $display("value errors %0d, hold errors %0d, cycles %0d",
         valueErrs, holdErrs, cycleCount);
      if (valueErrs == 0 && holdErrs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("timeout: run still going after %0d cycles", cycleCount);
         $display(">>> FAIL");
         $finish;
      end
   end

endmodule

// File: build.f
+incdir+tests
logic/isaPkg.sv
logic/fetchPkg.sv
logic/pcSequencer.sv
logic/instrMemory.sv
logic/hazardUnit.sv
logic/fetchStage.sv
tests/fetchStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the fetch stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f build.f \
   --top-module fetchStageTb \
   -o fetchStageSim

./obj_dir/fetchStageSim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

echo "simulation finished without failure"

// File: imem.hex
// one 16-bit instruction word per line, hex, starting at word 0
// fields: opcode[15:11] rs[10:8] rt[7:5] low[4:0]
D940
8A61
6304
0800
D4A0
85C0
E6E0
4725
2008
8B21
DA40
0800
9920
8C81
E140
6204
D8E0
8D01
0800
4A65
D620
8A41
